/* apb_subsystem_top.f */
apb_bridge_pkg.sv
apb_addr_decoder.sv
axi_lite_apb_bridge.sv
apb_reg_target.sv
apb_subsystem_top.sv
tb_apb_subsystem.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the AXI4-Lite to APB subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f apb_subsystem_top.f --top-module tb_apb_subsystem || exit 1

sim_out="$(./obj_dir/Vtb_apb_subsystem)"
echo "$sim_out"

echo "$sim_out" | grep -q "Result: PASSED" && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* tb_apb_subsystem.sv */
`timescale 1ns/1ps

module tb_apb_subsystem;

  import apb_bridge_pkg::*;

  localparam addr_t MAP_BASE    = 32'h0103_0000;
  localparam addr_t MAP_WINDOW  = 32'h100;
  localparam int    NUM_TARGETS = 3;
  // About 60 transactions of at most 16 cycles each, with a wide margin
  localparam int    MAX_CYCLES  = 4000;

  logic  clk;
  logic  reset_i;
  addr_t aw_addr_i;
  logic  aw_valid_i;
  logic  aw_ready_o;
  data_t w_data_i;
  strb_t w_strb_i;
  logic  w_valid_i;
  logic  w_ready_o;
  resp_t b_resp_o;
  logic  b_valid_o;
  logic  b_ready_i;
  addr_t ar_addr_i;
  logic  ar_valid_i;
  logic  ar_ready_o;
  data_t r_data_o;
  resp_t r_resp_o;
  logic  r_valid_o;
  logic  r_ready_i;

  int    errors;
  int    cycles;
  data_t model [NUM_TARGETS][3];

  // Expected responses, oldest first
  resp_t wr_resp_q [$];
  string wr_name_q [$];
  data_t rd_data_q [$];
  resp_t rd_resp_q [$];
  string rd_name_q [$];

  apb_subsystem_top u_apb_subsystem_top (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------------------
  function automatic int target_of(input addr_t addr);
    if ((addr < MAP_BASE) || (addr >= MAP_BASE + NUM_TARGETS * MAP_WINDOW)) begin
      return -1;
    end
    return int'((addr - MAP_BASE) / MAP_WINDOW);
  endfunction

  function automatic int wait_of(input int tgt);
    case (tgt)
      0: return 0;
      1: return 1;
      default: return 3;
    endcase
  endfunction

  function automatic data_t id_of(input int tgt);
    case (tgt)
      0: return 32'h6770_0000;
      1: return 32'h7561_0001;
      default: return 32'h7370_0002;
    endcase
  endfunction

  // Unmapped answers one cycle after the handshake, mapped after W+3
  function automatic int expected_latency(input addr_t addr);
    int tgt;
    tgt = target_of(addr);
    return (tgt < 0) ? 1 : wait_of(tgt) + 3;
  endfunction

  function automatic void ref_access(input logic wr, input addr_t addr, input data_t wdata,
                                     input strb_t strb, output resp_t resp, output data_t rdata);
    int tgt;
    int word;
    tgt   = target_of(addr);
    word  = int'(addr[3:2]);
    resp  = RESP_OKAY;
    rdata = '0;
    if (tgt < 0) begin
      resp = RESP_DECERR;
    end else if (word == 3) begin
      if (wr) resp = RESP_SLVERR;
      else rdata = id_of(tgt);
    end else if (wr) begin
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) model[tgt][word][8*b +: 8] = wdata[8*b +: 8];
      end
    end else begin
      rdata = model[tgt][word];
    end
  endfunction

  // ----------------------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------------------
  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (exp !== act) begin
      errors++;
      $display("mismatch %s data: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_resp(input string name, input resp_t exp, input resp_t act);
    if (exp !== act) begin
      errors++;
      $display("mismatch %s resp: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_latency(input string name, input int exp, input int act);
    if (exp != act) begin
      errors++;
      $display("mismatch %s latency: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  // Each response is matched at the negedge before its handshake edge
  always @(negedge clk) begin : compare_responses
    string nm;
    resp_t er;
    data_t ed;
    if (!reset_i && b_valid_o && b_ready_i) begin
      if (wr_resp_q.size() == 0) begin
        errors++;
        $display("write response arrived with no write outstanding");
      end else begin
        nm = wr_name_q.pop_front();
        er = wr_resp_q.pop_front();
        check_resp(nm, er, b_resp_o);
      end
    end
    if (!reset_i && r_valid_o && r_ready_i) begin
      if (rd_resp_q.size() == 0) begin
        errors++;
        $display("read response arrived with no read outstanding");
      end else begin
        nm = rd_name_q.pop_front();
        er = rd_resp_q.pop_front();
        ed = rd_data_q.pop_front();
        check_resp(nm, er, r_resp_o);
        check_data(nm, ed, r_data_o);
      end
    end
  end

  // ----------------------------------------------------------------------
  // AXI driver tasks
  // ----------------------------------------------------------------------
  task automatic finish_response(input logic wr, input int exp_lat, input string name);
    int   lat;
    int   hold;
    logic vld;
    lat = 0;
    vld = 1'b0;
    while (!vld) begin
      @(negedge clk);
      lat++;
      vld = wr ? b_valid_o : r_valid_o;
    end
    check_latency(name, exp_lat, lat);
    // Back-pressure before taking the response
    hold = $urandom_range(0, 3);
    repeat (hold) begin
      @(negedge clk);
      vld = wr ? b_valid_o : r_valid_o;
      if (!vld) begin
        errors++;
        $display("%s: response valid dropped while ready was low", name);
      end
    end
    @(posedge clk);
    #1;
    if (wr) b_ready_i = 1'b1;
    else r_ready_i = 1'b1;
    @(posedge clk);
    #1;
    b_ready_i = 1'b0;
    r_ready_i = 1'b0;
    @(negedge clk);
    vld = wr ? b_valid_o : r_valid_o;
    if (vld) begin
      errors++;
      $display("%s: response still valid after it was taken", name);
    end
  endtask

  task automatic axi_write(input string name, input addr_t addr, input data_t data,
                           input strb_t strb);
    resp_t er;
    data_t ed;
    ref_access(1'b1, addr, data, strb, er, ed);
    wr_resp_q.push_back(er);
    wr_name_q.push_back(name);
    @(posedge clk);
    #1;
    aw_addr_i  = addr;
    w_data_i   = data;
    w_strb_i   = strb;
    aw_valid_i = 1'b1;
    w_valid_i  = 1'b1;
    do @(negedge clk); while (!(aw_ready_o && w_ready_o));
    @(posedge clk);
    #1;
    aw_valid_i = 1'b0;
    w_valid_i  = 1'b0;
    finish_response(1'b1, expected_latency(addr), name);
  endtask

  task automatic axi_read(input string name, input addr_t addr);
    resp_t er;
    data_t ed;
    ref_access(1'b0, addr, '0, '0, er, ed);
    rd_resp_q.push_back(er);
    rd_data_q.push_back(ed);
    rd_name_q.push_back(name);
    @(posedge clk);
    #1;
    ar_addr_i  = addr;
    ar_valid_i = 1'b1;
    do @(negedge clk); while (!ar_ready_o);
    @(posedge clk);
    #1;
    ar_valid_i = 1'b0;
    finish_response(1'b0, expected_latency(addr), name);
  endtask

  function automatic addr_t word_addr(input int tgt, input int word);
    return MAP_BASE + addr_t'(tgt) * MAP_WINDOW + addr_t'(word * 4);
  endfunction

  // ----------------------------------------------------------------------
  // Timeout
  // ----------------------------------------------------------------------
  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("Result: FAILED");
    $finish;
  end

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin
    addr_t bad_addr [4];
    int    w;
    void'($urandom(32'h62d5_1fa5));
    bad_addr = '{32'h0102_fffc, 32'h0103_0300, 32'h0000_0000, 32'hffff_fff0};
    errors     = 0;
    reset_i    = 1'b1;
    aw_addr_i  = '0;
    aw_valid_i = 1'b0;
    w_data_i   = '0;
    w_strb_i   = '0;
    w_valid_i  = 1'b0;
    b_ready_i  = 1'b0;
    ar_addr_i  = '0;
    ar_valid_i = 1'b0;
    r_ready_i  = 1'b0;
    for (int t = 0; t < NUM_TARGETS; t++) begin
      for (int k = 0; k < 3; k++) model[t][k] = '0;
    end
    repeat (2) @(posedge clk);
    #1;
    reset_i = 1'b0;

    // Full word write and readback
    for (int t = 0; t < NUM_TARGETS; t++) begin
      for (int k = 0; k < 3; k++) begin
        axi_write($sformatf("scratch_wr t%0d w%0d", t, k), word_addr(t, k), $urandom, 4'hf);
        axi_read($sformatf("scratch_rd t%0d w%0d", t, k), word_addr(t, k));
      end
    end

    // Byte lane merge
    for (int t = 0; t < NUM_TARGETS; t++) begin
      for (int k = 0; k < 4; k++) begin
        w = $urandom_range(0, 2);
        axi_write($sformatf("strb_wr t%0d #%0d", t, k), word_addr(t, w), $urandom,
                  strb_t'($urandom_range(1, 14)));
        axi_read($sformatf("strb_rd t%0d #%0d", t, k), word_addr(t, w));
      end
    end

    // Identity word is read only
    for (int t = 0; t < NUM_TARGETS; t++) begin
      axi_read($sformatf("id_rd t%0d", t), word_addr(t, 3));
      axi_write($sformatf("id_wr t%0d", t), word_addr(t, 3), $urandom, 4'hf);
      axi_read($sformatf("id_reread t%0d", t), word_addr(t, 3));
    end

    // Unmapped addresses, then scratch must be untouched
    for (int i = 0; i < 4; i++) begin
      axi_write($sformatf("unmapped_wr %h", bad_addr[i]), bad_addr[i], $urandom, 4'hf);
      axi_read($sformatf("unmapped_rd %h", bad_addr[i]), bad_addr[i]);
    end
    for (int t = 0; t < NUM_TARGETS; t++) begin
      for (int k = 0; k < 3; k++) begin
        axi_read($sformatf("keep_rd t%0d w%0d", t, k), word_addr(t, k));
      end
    end

    repeat (2) @(posedge clk);
    if ((wr_resp_q.size() != 0) || (rd_resp_q.size() != 0)) begin
      errors++;
      $display("responses still missing at the end of the run");
    end
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* apb_subsystem_top.sv */
`timescale 1ns/1ps

module apb_subsystem_top #(
  parameter int                    APB_TARGETS              = 3,
  parameter apb_bridge_pkg::addr_t ADDR_BASE                = 32'h0103_0000,
  parameter apb_bridge_pkg::addr_t TARGET_SIZE              = 32'h100,
  parameter int unsigned           WAIT_CYCLES [APB_TARGETS] = '{0, 1, 3},
  parameter apb_bridge_pkg::data_t TARGET_ID [APB_TARGETS]   =
    '{32'h6770_0000, 32'h7561_0001, 32'h7370_0002}
) (
  input  logic                  clk,
  input  logic                  reset_i,
  input  apb_bridge_pkg::addr_t aw_addr_i,
  input  logic                  aw_valid_i,
  output logic                  aw_ready_o,
  input  apb_bridge_pkg::data_t w_data_i,
  input  apb_bridge_pkg::strb_t w_strb_i,
  input  logic                  w_valid_i,
  output logic                  w_ready_o,
  output apb_bridge_pkg::resp_t b_resp_o,
  output logic                  b_valid_o,
  input  logic                  b_ready_i,
  input  apb_bridge_pkg::addr_t ar_addr_i,
  input  logic                  ar_valid_i,
  output logic                  ar_ready_o,
  output apb_bridge_pkg::data_t r_data_o,
  output apb_bridge_pkg::resp_t r_resp_o,
  output logic                  r_valid_o,
  input  logic                  r_ready_i
);

  import apb_bridge_pkg::*;

  addr_t                   dec_addr;
  logic [APB_TARGETS-1:0]  dec_sel;
  logic                    dec_miss;

  addr_t                   paddr;
  logic                    pwrite;
  data_t                   pwdata;
  strb_t                   pstrb;
  logic [APB_TARGETS-1:0]  psel;
  logic                    penable;
  data_t [APB_TARGETS-1:0] prdata;
  logic [APB_TARGETS-1:0]  pready;
  logic [APB_TARGETS-1:0]  pslverr;

  axi_lite_apb_bridge #(
    .APB_TARGETS(APB_TARGETS)
  ) u_bridge (
    .clk        (clk),
    .reset_i    (reset_i),
    .aw_addr_i  (aw_addr_i),
    .aw_valid_i (aw_valid_i),
    .aw_ready_o (aw_ready_o),
    .w_data_i   (w_data_i),
    .w_strb_i   (w_strb_i),
    .w_valid_i  (w_valid_i),
    .w_ready_o  (w_ready_o),
    .b_resp_o   (b_resp_o),
    .b_valid_o  (b_valid_o),
    .b_ready_i  (b_ready_i),
    .ar_addr_i  (ar_addr_i),
    .ar_valid_i (ar_valid_i),
    .ar_ready_o (ar_ready_o),
    .r_data_o   (r_data_o),
    .r_resp_o   (r_resp_o),
    .r_valid_o  (r_valid_o),
    .r_ready_i  (r_ready_i),
    .dec_addr_o (dec_addr),
    .dec_sel_i  (dec_sel),
    .dec_miss_i (dec_miss),
    .paddr_o    (paddr),
    .pwrite_o   (pwrite),
    .pwdata_o   (pwdata),
    .pstrb_o    (pstrb),
    .psel_o     (psel),
    .penable_o  (penable),
    .prdata_i   (prdata),
    .pready_i   (pready),
    .pslverr_i  (pslverr)
  );

  apb_addr_decoder #(
    .APB_TARGETS (APB_TARGETS),
    .ADDR_BASE   (ADDR_BASE),
    .TARGET_SIZE (TARGET_SIZE)
  ) u_decoder (
    .addr_i (dec_addr),
    .sel_o  (dec_sel),
    .miss_o (dec_miss)
  );

  // Windows in order gpio, uart, spi
  for (genvar i = 0; i < APB_TARGETS; i++) begin : g_target
    apb_reg_target #(
      .WAIT_CYCLES (WAIT_CYCLES[i]),
      .TARGET_ID   (TARGET_ID[i])
    ) u_target (
      .clk       (clk),
      .reset_i   (reset_i),
      .paddr_i   (paddr),
      .psel_i    (psel[i]),
      .penable_i (penable),
      .pwrite_i  (pwrite),
      .pwdata_i  (pwdata),
      .pstrb_i   (pstrb),
      .prdata_o  (prdata[i]),
      .pready_o  (pready[i]),
      .pslverr_o (pslverr[i])
    );
  end

endmodule

/* apb_reg_target.sv */
`timescale 1ns/1ps

module apb_reg_target #(
  parameter int unsigned           WAIT_CYCLES = 0,
  parameter apb_bridge_pkg::data_t TARGET_ID   = 32'h0000_0000
) (
  input  logic                  clk,
  input  logic                  reset_i,
  input  apb_bridge_pkg::addr_t paddr_i,
  input  logic                  psel_i,
  input  logic                  penable_i,
  input  logic                  pwrite_i,
  input  apb_bridge_pkg::data_t pwdata_i,
  input  apb_bridge_pkg::strb_t pstrb_i,
  output apb_bridge_pkg::data_t prdata_o,
  output logic                  pready_o,
  output logic                  pslverr_o
);

  import apb_bridge_pkg::*;

  localparam int CW = (WAIT_CYCLES > 0) ? $clog2(WAIT_CYCLES + 1) : 1;

  data_t           scratch_q [3];
  logic [CW-1:0]   wait_q;
  logic [1:0]      word_idx;
  logic            access;

  // Only bits [3:2] pick a word inside the window
  assign word_idx = paddr_i[3:2];
  assign access   = psel_i && penable_i;

  // Wait state counter, runs only while the access is stalled
  always_ff @(posedge clk) begin
    if (reset_i) begin
      wait_q <= '0;
    end else if (access && !pready_o) begin
      wait_q <= wait_q + 1'b1;
    end else begin
      wait_q <= '0;
    end
  end

  assign pready_o  = access && (wait_q == CW'(WAIT_CYCLES));
  // Identity word is read only
  assign pslverr_o = access && pwrite_i && (word_idx == 2'd3);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 0; i < 3; i++) begin
        scratch_q[i] <= '0;
      end
    end else if (pready_o && pwrite_i && (word_idx != 2'd3)) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (pstrb_i[b]) begin
          scratch_q[word_idx][8*b +: 8] <= pwdata_i[8*b +: 8];
        end
      end
    end
  end

  assign prdata_o = (word_idx == 2'd3) ? TARGET_ID : scratch_q[word_idx];

endmodule

/* axi_lite_apb_bridge.sv */
`timescale 1ns/1ps

module axi_lite_apb_bridge #(
  parameter int APB_TARGETS = 3
) (
  input  logic                                    clk,
  input  logic                                    reset_i,

  // AXI4-Lite slave
  input  apb_bridge_pkg::addr_t                   aw_addr_i,
  input  logic                                    aw_valid_i,
  output logic                                    aw_ready_o,
  input  apb_bridge_pkg::data_t                   w_data_i,
  input  apb_bridge_pkg::strb_t                   w_strb_i,
  input  logic                                    w_valid_i,
  output logic                                    w_ready_o,
  output apb_bridge_pkg::resp_t                   b_resp_o,
  output logic                                    b_valid_o,
  input  logic                                    b_ready_i,
  input  apb_bridge_pkg::addr_t                   ar_addr_i,
  input  logic                                    ar_valid_i,
  output logic                                    ar_ready_o,
  output apb_bridge_pkg::data_t                   r_data_o,
  output apb_bridge_pkg::resp_t                   r_resp_o,
  output logic                                    r_valid_o,
  input  logic                                    r_ready_i,

  // Address decoder
  output apb_bridge_pkg::addr_t                   dec_addr_o,
  input  logic [APB_TARGETS-1:0]                  dec_sel_i,
  input  logic                                    dec_miss_i,

  // APB master
  output apb_bridge_pkg::addr_t                   paddr_o,
  output logic                                    pwrite_o,
  output apb_bridge_pkg::data_t                   pwdata_o,
  output apb_bridge_pkg::strb_t                   pstrb_o,
  output logic [APB_TARGETS-1:0]                  psel_o,
  output logic                                    penable_o,
  input  apb_bridge_pkg::data_t [APB_TARGETS-1:0] prdata_i,
  input  logic [APB_TARGETS-1:0]                  pready_i,
  input  logic [APB_TARGETS-1:0]                  pslverr_i
);

  import apb_bridge_pkg::*;

  bridge_state_e          state_q;
  logic                   write_q;
  logic [APB_TARGETS-1:0] psel_q;
  logic                   penable_q;
  addr_t                  addr_q;
  data_t                  wdata_q;
  strb_t                  strb_q;
  data_t                  rdata_q;
  resp_t                  resp_q;

  logic                   wr_req;
  logic                   wr_accept;
  logic                   rd_accept;
  data_t                  sel_rdata;
  logic                   sel_ready;
  logic                   sel_err;

  // ----------------------------------------------------------------------
  // AXI acceptance
  // ----------------------------------------------------------------------
  // Address and data are only taken together; writes win over reads
  assign wr_req     = aw_valid_i && w_valid_i;
  assign wr_accept  = (state_q == IDLE) && wr_req;
  assign rd_accept  = (state_q == IDLE) && ar_valid_i && !wr_req;
  assign aw_ready_o = wr_accept;
  assign w_ready_o  = wr_accept;
  assign ar_ready_o = rd_accept;

  // Decode the incoming address in IDLE so a miss skips APB entirely
  assign dec_addr_o = (state_q != IDLE) ? addr_q :
                      (wr_req ? aw_addr_i : ar_addr_i);

  // Response lines from whichever target is selected
  always_comb begin
    sel_rdata = '0;
    sel_ready = 1'b0;
    sel_err   = 1'b0;
    for (int i = 0; i < APB_TARGETS; i++) begin
      if (psel_q[i]) begin
        sel_rdata = sel_rdata | prdata_i[i];
        sel_ready = sel_ready | pready_i[i];
        sel_err   = sel_err | pslverr_i[i];
      end
    end
  end

  // ----------------------------------------------------------------------
  // Control
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q   <= IDLE;
      write_q   <= 1'b0;
      psel_q    <= '0;
      penable_q <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (wr_accept || rd_accept) begin
            write_q <= wr_accept;
            if (dec_miss_i) begin
              state_q <= RESP;
            end else begin
              psel_q  <= dec_sel_i;
              state_q <= SETUP;
            end
          end
        end
        SETUP: begin
          penable_q <= 1'b1;
          state_q   <= ACCESS;
        end
        ACCESS: begin
          if (sel_ready) begin
            psel_q    <= '0;
            penable_q <= 1'b0;
            state_q   <= RESP;
          end
        end
        RESP: begin
          if ((write_q && b_ready_i) || (!write_q && r_ready_i)) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // Payload
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (wr_accept) begin
      addr_q  <= aw_addr_i;
      wdata_q <= w_data_i;
      strb_q  <= w_strb_i;
    end else if (rd_accept) begin
      addr_q  <= ar_addr_i;
      wdata_q <= '0;
      strb_q  <= '0;
    end
    if ((wr_accept || rd_accept) && dec_miss_i) begin
      resp_q  <= RESP_DECERR;
      rdata_q <= '0;
    end else if ((state_q == ACCESS) && sel_ready) begin
      resp_q  <= sel_err ? RESP_SLVERR : RESP_OKAY;
      rdata_q <= sel_rdata;
    end
  end

  assign paddr_o   = addr_q;
  assign pwrite_o  = write_q;
  assign pwdata_o  = wdata_q;
  assign pstrb_o   = strb_q;
  assign psel_o    = psel_q;
  assign penable_o = penable_q;

  assign b_valid_o = (state_q == RESP) && write_q;
  assign b_resp_o  = resp_q;
  assign r_valid_o = (state_q == RESP) && !write_q;
  assign r_resp_o  = resp_q;
  assign r_data_o  = rdata_q;

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------
  // Everything launched in SETUP holds until the target is ready
  a_apb_stable : assert property (@(posedge clk) disable iff (reset_i)
    penable_o |-> $stable(paddr_o) && $stable(pwrite_o) && $stable(pwdata_o)
                  && $stable(pstrb_o) && $stable(psel_o))
    else $error("axi_lite_apb_bridge: APB outputs changed in ACCESS");

  a_penable_psel : assert property (@(posedge clk) disable iff (reset_i)
    penable_o |-> |psel_o)
    else $error("axi_lite_apb_bridge: penable without psel");

  // Write response is not dropped under back-pressure
  a_b_hold : assert property (@(posedge clk) disable iff (reset_i)
    b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_resp_o))
    else $error("axi_lite_apb_bridge: b_valid dropped before b_ready");

endmodule

/* apb_addr_decoder.sv */
`timescale 1ns/1ps

module apb_addr_decoder #(
  parameter int                    APB_TARGETS = 3,
  parameter apb_bridge_pkg::addr_t ADDR_BASE   = 32'h0103_0000,
  parameter apb_bridge_pkg::addr_t TARGET_SIZE = 32'h100
) (
  input  apb_bridge_pkg::addr_t  addr_i,
  output logic [APB_TARGETS-1:0] sel_o,
  output logic                   miss_o
);

  import apb_bridge_pkg::*;

  // Windows are laid out back to back from ADDR_BASE
  always_comb begin
    addr_t lo;
    addr_t hi;
    sel_o = '0;
    for (int i = 0; i < APB_TARGETS; i++) begin
      lo = ADDR_BASE + addr_t'(i) * TARGET_SIZE;
      hi = lo + TARGET_SIZE;
      if ((addr_i >= lo) && (addr_i < hi)) begin
        sel_o[i] = 1'b1;
      end
    end
  end

  // Nothing matched, bridge answers DECERR
  assign miss_o = ~|sel_o;

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------
  // Overlapping windows from a bad parameter set would show up here
  a_sel_onehot0 : assert property (@(addr_i) $onehot0(sel_o))
    else $error("apb_addr_decoder: select not one-hot for %h", addr_i);

endmodule

/* apb_bridge_pkg.sv */
package apb_bridge_pkg;

  // ----------------------------------------------------------------------
  // Bus widths
  // ----------------------------------------------------------------------
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  // Byte address, shared by AXI and APB sides
  typedef logic [ADDR_W-1:0] addr_t;

  // One data word
  typedef logic [DATA_W-1:0] data_t;

  // Byte lane enables
  typedef logic [STRB_W-1:0] strb_t;

  // ----------------------------------------------------------------------
  // AXI response codes
  // ----------------------------------------------------------------------
  typedef logic [1:0] resp_t;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;
  localparam resp_t RESP_DECERR = 2'b11;

  // ----------------------------------------------------------------------
  // Bridge sequencing
  // ----------------------------------------------------------------------
  // IDLE waits for AXI, SETUP and ACCESS are the APB phases,
  // RESP holds the AXI response until it is taken
  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    ACCESS,
    RESP
  } bridge_state_e;

endpackage
